// ==== design/cache_ctrl_params.svh ====
`ifndef CACHE_CTRL_PARAMS_SVH
`define CACHE_CTRL_PARAMS_SVH

// widths shared by the L1/L2 side and the main-memory side

`define CC_ADDR_W 19 // L1 and L2 line address width

`define CC_WORD_W 32 // one main-memory word and one main-memory address

`define CC_BLOCK_W 128 // a full cache line

`define CC_BEATS 4 // memory words needed to fill one line

`define CC_BE_W 16 // one enable bit per byte of the L2 line

`define CC_LINE_OFS 4 // low address bits that select a byte inside a line

// the upper 13 bits of every main-memory read address
`define CC_RAM_BASE 13'h0800

`define CC_NEXT_STEP 2 // the next line sits this far above the fetch address

`endif

// ==== design/cache_ctrl_pkg.sv ====
`include "cache_ctrl_params.svh"
`default_nettype none

package cache_ctrl_pkg;

    typedef logic [`CC_ADDR_W-1:0] l1_addr_t; // address as seen by L1 and L2

    typedef logic [`CC_WORD_W-1:0] ram_addr_t; // base bits on top of the cache address

    typedef logic [$clog2(`CC_BEATS)-1:0] beat_t; // which word of the line is moving

    // the port that currently holds the single main-memory read port
    typedef enum logic [1:0] {
        OWN_NONE  = 2'd0, // memory is free
        OWN_INSTR = 2'd1, // instruction refill in flight
        OWN_DATA  = 2'd2  // data refill in flight
    } owner_t;

    typedef enum logic [3:0] {
        IDLE      = 4'd0, // waits for a read request
        LOOKUP    = 4'd1, // L1 tag result is valid in this cycle
        SETTLE    = 4'd2, // gives the L2 read one cycle to come back
        L2_CHECK  = 4'd3, // decides between L2 hit and main-memory refill
        L1_FILL0  = 4'd4, // first half of the L1 write from L2
        L1_FILL1  = 4'd5, // second half of the L1 write, then wait for the L1 hit
        MEM_FILL  = 4'd6, // request memory and wait for the refill to end
        MEM_DONE0 = 4'd7, // first half of the L1 write after the refill
        MEM_DONE1 = 4'd8  // second half, then wait for the L1 hit
    } miss_state_t;

endpackage

`default_nettype wire

// ==== design/l1_miss_fsm.sv ====
`timescale 1ns/1ps
`include "cache_ctrl_params.svh"
`default_nettype none

module l1_miss_fsm #(
    parameter bit NEXT_LINE = 1'b0 // set on the instruction port for next-line prefetch
) (
    input  wire                       clk_i,
    input  wire                       rst_i,
    input  wire                       req_i,         // read request from the core
    input  wire cache_ctrl_pkg::l1_addr_t l1_addr_i, // address of the read
    input  wire                       l1_hit_i,      // L1 tag compare result
    input  wire                       miss_next_i,   // the following line is not in L1
    input  wire                       l2_hit_i,      // L2 tag compare result
    input  wire                       fill_done_i,   // last refill beat has been written
    output logic                      busy_o,
    output logic                      miss_o,
    output logic                      l2_read_o,
    output logic                      l1_write_o,    // two-cycle L1 line write
    output logic                      write_next_o,  // the fill targets the next line
    output logic                      fill_start_o,  // one-cycle marker at the start of a fill
    output logic                      l2_write_o,    // L2 takes the memory beats
    output logic                      fill_req_o,    // level request toward the arbiter
    output cache_ctrl_pkg::l1_addr_t  lookup_addr_o, // address given to L2
    output cache_ctrl_pkg::l1_addr_t  fill_addr_o    // line-aligned refill address
);

    import cache_ctrl_pkg::*;

    miss_state_t state_q;     // where this port is in the lookup/miss flow
    logic        next_sel;    // next-line address drives L2
    logic        lookup_miss; // current line or its successor must be fetched

    // a plain miss, or for the instruction port a hit whose next line is absent
    assign lookup_miss = !l1_hit_i || (NEXT_LINE && miss_next_i);

    // keep the next-line address once the miss has been flagged as a next-line miss
    assign next_sel = NEXT_LINE && (write_next_o || (l1_hit_i && miss_next_i));

    assign lookup_addr_o = next_sel ? l1_addr_i + l1_addr_t'(`CC_NEXT_STEP) : l1_addr_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= IDLE;
            busy_o       <= 1'b0;
            miss_o       <= 1'b0;
            l2_read_o    <= 1'b0;
            l1_write_o   <= 1'b0;
            write_next_o <= 1'b0;
            fill_start_o <= 1'b0;
            l2_write_o   <= 1'b0;
            fill_req_o   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        busy_o  <= 1'b1; // busy from the cycle after the request
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (lookup_miss) begin
                        miss_o       <= 1'b1;
                        l2_read_o    <= 1'b1; // start the L2 lookup right away
                        write_next_o <= NEXT_LINE && l1_hit_i && miss_next_i;
                        state_q      <= SETTLE;
                    end else begin
                        busy_o  <= 1'b0; // hit costs exactly one busy cycle
                        state_q <= IDLE;
                    end
                end
                SETTLE: begin
                    state_q <= L2_CHECK; // L2 answer is registered one cycle late
                end
                L2_CHECK: begin
                    fill_start_o <= 1'b1;
                    if (l2_hit_i) begin
                        l1_write_o <= 1'b1; // copy the line from L2 straight into L1
                        state_q    <= L1_FILL0;
                    end else begin
                        fill_req_o <= 1'b1; // ask for main memory and hold until done
                        l2_write_o <= 1'b1;
                        state_q    <= MEM_FILL;
                    end
                end
                L1_FILL0: begin
                    fill_start_o <= 1'b0;
                    state_q      <= L1_FILL1;
                end
                L1_FILL1: begin
                    l1_write_o <= 1'b0; // line is written in two halves
                    if (l1_hit_i) begin
                        busy_o       <= 1'b0;
                        miss_o       <= 1'b0;
                        l2_read_o    <= 1'b0;
                        write_next_o <= 1'b0;
                        state_q      <= IDLE;
                    end
                end
                MEM_FILL: begin
                    fill_start_o <= 1'b0;
                    if (fill_done_i) begin
                        fill_req_o <= 1'b0; // drop on the same edge the arbiter frees memory
                        l2_write_o <= 1'b0;
                        l1_write_o <= 1'b1;
                        state_q    <= MEM_DONE0;
                    end
                end
                MEM_DONE0: begin
                    state_q <= MEM_DONE1;
                end
                MEM_DONE1: begin
                    l1_write_o <= 1'b0;
                    if (!lookup_miss) begin // line present and, on instr, next line too
                        busy_o       <= 1'b0;
                        miss_o       <= 1'b0;
                        l2_read_o    <= 1'b0;
                        write_next_o <= 1'b0;
                        state_q      <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // line-aligned address for the sequencer, taken on the L2 miss decision
    always_ff @(posedge clk_i) begin
        if (state_q == L2_CHECK && !l2_hit_i) begin
            fill_addr_o <= {lookup_addr_o[`CC_ADDR_W-1:`CC_LINE_OFS], {`CC_LINE_OFS{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_read_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_read_arbiter (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     instr_req_i,  // instruction port wants a refill
    input  wire                     data_req_i,   // data port wants a refill
    input  wire                     instr_done_i, // instruction refill finished
    input  wire                     data_done_i,  // data refill finished
    output cache_ctrl_pkg::owner_t  owner_o       // who may drive the memory read port
);

    import cache_ctrl_pkg::*;

    // memory has one read port so only one line moves at a time
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            owner_o <= OWN_NONE;
        end else begin
            case (owner_o)
                OWN_NONE: begin
                    if (instr_req_i) begin
                        owner_o <= OWN_INSTR; // fetch stalls the core hardest so it goes first
                    end else if (data_req_i) begin
                        owner_o <= OWN_DATA;
                    end
                end
                OWN_INSTR: begin
                    if (instr_done_i) begin
                        owner_o <= OWN_NONE; // requester drops its level on this same edge
                    end
                end
                OWN_DATA: begin
                    if (data_done_i) begin
                        owner_o <= OWN_NONE;
                    end
                end
                default: owner_o <= OWN_NONE;
            endcase
        end
    end

    // a waiting data request stays raised and is picked up once memory
    // returns to OWN_NONE, so no refill is lost while the other one runs

endmodule

`default_nettype wire

// ==== design/refill_seq.sv ====
`timescale 1ns/1ps
`include "cache_ctrl_params.svh"
`default_nettype none

module refill_seq (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire cache_ctrl_pkg::owner_t owner_i,      // current holder of memory
    input  wire cache_ctrl_pkg::l1_addr_t instr_addr_i, // aligned instruction fill line
    input  wire cache_ctrl_pkg::l1_addr_t data_addr_i,  // aligned data fill line
    input  wire                         ram_done_i,   // memory has returned the current word
    output logic                        ram_read_o,
    output cache_ctrl_pkg::ram_addr_t   ram_read_addr_o,
    output logic [`CC_BE_W-1:0]         l2_p1_be_o,   // data side L2 byte enable
    output logic [`CC_BE_W-1:0]         l2_p2_be_o,   // instruction side L2 byte enable
    output logic                        instr_done_o,
    output logic                        data_done_o
);

    import cache_ctrl_pkg::*;

    beat_t               beat_q;     // word of the line being fetched
    logic                active;     // a refill is running
    logic                last_pulse; // memory answered the final word
    l1_addr_t            sel_addr;   // line address of the owner
    l1_addr_t            beat_ofs;   // byte offset of the current word
    logic [`CC_BE_W-1:0] beat_be;    // nibble of the line the current word lands in

    assign active     = (owner_i != OWN_NONE); // the arbiter grant starts the refill
    assign sel_addr   = (owner_i == OWN_INSTR) ? instr_addr_i : data_addr_i;
    assign beat_ofs   = l1_addr_t'({beat_q, 2'b00}); // four bytes per memory word
    assign last_pulse = active && ram_done_i && (beat_q == beat_t'(`CC_BEATS - 1));

    // read stays raised for the whole line and memory paces it with ram_done_i
    assign ram_read_o      = active;
    assign ram_read_addr_o = {`CC_RAM_BASE, sel_addr + beat_ofs};

    always_comb begin
        case (beat_q)
            2'd0:    beat_be = 16'h000F;
            2'd1:    beat_be = 16'h00F0;
            2'd2:    beat_be = 16'h0F00;
            default: beat_be = 16'hF000;
        endcase
    end

    // only the owning port may see an enable so the other L2 port stays untouched
    assign l2_p1_be_o = (owner_i == OWN_DATA) ? beat_be : '0;
    assign l2_p2_be_o = (owner_i == OWN_INSTR) ? beat_be : '0;

    // done goes out on the edge of the fourth word, to the owner only
    assign instr_done_o = last_pulse && (owner_i == OWN_INSTR);
    assign data_done_o  = last_pulse && (owner_i == OWN_DATA);

    always_ff @(posedge clk_i) begin
        if (rst_i || !active) begin
            beat_q <= '0; // every refill starts at the first word
        end else if (ram_done_i) begin
            beat_q <= beat_q + 1'b1; // wraps to the first word after the last one
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_ctrl_top.sv ====
`timescale 1ns/1ps
`include "cache_ctrl_params.svh"
`default_nettype none

module cache_ctrl_top (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire                          instr_req_i,
    input  wire cache_ctrl_pkg::l1_addr_t instr_addr_i,
    input  wire                          instr_l1_hit_i,
    input  wire                          instr_miss_next_i,
    input  wire                          instr_l2_hit_i,
    input  wire                          data_req_i,
    input  wire cache_ctrl_pkg::l1_addr_t data_addr_i,
    input  wire                          data_l1_hit_i,
    input  wire                          data_l2_hit_i,
    input  wire                          ram_done_i,
    output logic                         instr_busy_o,
    output logic                         instr_miss_o,
    output logic                         instr_l2_read_o,
    output logic                         instr_l1_write_o,
    output logic                         instr_write_next_o,
    output logic                         instr_fill_start_o,
    output logic                         l2_p2_write_o,
    output logic [`CC_BE_W-1:0]          l2_p2_be_o,
    output cache_ctrl_pkg::l1_addr_t     l2_p2_addr_o,
    output logic                         data_busy_o,
    output logic                         data_miss_o,
    output logic                         data_l2_read_o,
    output logic                         data_l1_write_o,
    output logic                         data_fill_start_o,
    output logic                         l2_p1_write_o,
    output logic [`CC_BE_W-1:0]          l2_p1_be_o,
    output logic                         ram_read_o,
    output cache_ctrl_pkg::ram_addr_t    ram_read_addr_o
);

    import cache_ctrl_pkg::*;

    owner_t   owner;           // memory grant from the arbiter
    logic     instr_fill_req;  // instruction port waits for memory
    logic     data_fill_req;   // data port waits for memory
    logic     instr_done;      // end of the instruction refill
    logic     data_done;       // end of the data refill
    l1_addr_t instr_fill_addr; // aligned instruction refill line
    l1_addr_t data_fill_addr;  // aligned data refill line

    // instruction side keeps next-line prefetch and owns L2 port 2
    l1_miss_fsm #(.NEXT_LINE(1'b1)) u_instr (
        .clk_i(clk_i), .rst_i(rst_i), .req_i(instr_req_i), .l1_addr_i(instr_addr_i),
        .l1_hit_i(instr_l1_hit_i), .miss_next_i(instr_miss_next_i),
        .l2_hit_i(instr_l2_hit_i), .fill_done_i(instr_done),
        .busy_o(instr_busy_o), .miss_o(instr_miss_o), .l2_read_o(instr_l2_read_o),
        .l1_write_o(instr_l1_write_o), .write_next_o(instr_write_next_o),
        .fill_start_o(instr_fill_start_o), .l2_write_o(l2_p2_write_o),
        .fill_req_o(instr_fill_req), .lookup_addr_o(l2_p2_addr_o),
        .fill_addr_o(instr_fill_addr)
    );

    // data side has no next-line path and owns L2 port 1
    l1_miss_fsm #(.NEXT_LINE(1'b0)) u_data (
        .clk_i(clk_i), .rst_i(rst_i), .req_i(data_req_i), .l1_addr_i(data_addr_i),
        .l1_hit_i(data_l1_hit_i), .miss_next_i(1'b0),
        .l2_hit_i(data_l2_hit_i), .fill_done_i(data_done),
        .busy_o(data_busy_o), .miss_o(data_miss_o), .l2_read_o(data_l2_read_o),
        .l1_write_o(data_l1_write_o), .write_next_o(),
        .fill_start_o(data_fill_start_o), .l2_write_o(l2_p1_write_o),
        .fill_req_o(data_fill_req), .lookup_addr_o(), .fill_addr_o(data_fill_addr)
    );

    mem_read_arbiter u_arb (
        .clk_i(clk_i), .rst_i(rst_i), .instr_req_i(instr_fill_req), .data_req_i(data_fill_req),
        .instr_done_i(instr_done), .data_done_i(data_done), .owner_o(owner)
    );

    refill_seq u_refill (
        .clk_i(clk_i), .rst_i(rst_i), .owner_i(owner), .instr_addr_i(instr_fill_addr),
        .data_addr_i(data_fill_addr), .ram_done_i(ram_done_i), .ram_read_o(ram_read_o),
        .ram_read_addr_o(ram_read_addr_o), .l2_p1_be_o(l2_p1_be_o), .l2_p2_be_o(l2_p2_be_o),
        .instr_done_o(instr_done), .data_done_o(data_done)
    );

endmodule

`default_nettype wire

// ==== verif/cache_ctrl_chk.sv ====
`timescale 1ns/1ps
`include "cache_ctrl_params.svh"
`default_nettype none

module cache_ctrl_chk (
    input wire                            clk_i,
    input wire                            rst_i,
    input wire                            ram_read_i,
    input wire cache_ctrl_pkg::ram_addr_t ram_read_addr_i,
    input wire [`CC_BE_W-1:0]             l2_p1_be_i,
    input wire [`CC_BE_W-1:0]             l2_p2_be_i,
    input wire                            instr_fill_start_i,
    input wire                            data_fill_start_i,
    input wire [12:0]                     ctrl_i // registered control outputs of both ports
);

    int unsigned fail_cnt = 0; // number of failed assertions so far

    // one refill at a time, so only one L2 port can take a beat
    be_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !((l2_p1_be_i != '0) && (l2_p2_be_i != '0)))
        else begin
            fail_cnt++;
            $error("L2 byte enables active on both ports");
        end

    // memory reads sit above the base and on a word boundary
    ram_addr_form: assert property (@(posedge clk_i) disable iff (rst_i)
        ram_read_i |-> (ram_read_addr_i[`CC_WORD_W-1:`CC_ADDR_W] == `CC_RAM_BASE)
                       && (ram_read_addr_i[1:0] == 2'b00))
        else begin
            fail_cnt++;
            $error("main-memory read address 0x%08h is malformed", ram_read_addr_i);
        end

    instr_start_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_fill_start_i |=> !instr_fill_start_i)
        else begin
            fail_cnt++;
            $error("instruction fill start held longer than one cycle");
        end

    data_start_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        data_fill_start_i |=> !data_fill_start_i)
        else begin
            fail_cnt++;
            $error("data fill start held longer than one cycle");
        end

    // first cycle out of reset, everything is quiet
    reset_quiet: assert property (@(posedge clk_i)
        $fell(rst_i) |-> (ctrl_i == '0) && !ram_read_i
                         && (l2_p1_be_i == '0) && (l2_p2_be_i == '0))
        else begin
            fail_cnt++;
            $error("control outputs not cleared by reset");
        end

endmodule

bind cache_ctrl_top cache_ctrl_chk u_chk (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .ram_read_i(ram_read_o),
    .ram_read_addr_i(ram_read_addr_o),
    .l2_p1_be_i(l2_p1_be_o),
    .l2_p2_be_i(l2_p2_be_o),
    .instr_fill_start_i(instr_fill_start_o),
    .data_fill_start_i(data_fill_start_o),
    .ctrl_i({instr_busy_o, instr_miss_o, instr_l2_read_o, instr_l1_write_o,
             instr_write_next_o, instr_fill_start_o, l2_p2_write_o, data_busy_o,
             data_miss_o, data_l2_read_o, data_l1_write_o, data_fill_start_o,
             l2_p1_write_o})
);

`default_nettype wire

// ==== verif/cache_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "cache_ctrl_params.svh"
`default_nettype none

module cache_ctrl_tb;

    import cache_ctrl_pkg::*;

    localparam int WAIT_LIMIT  = 200; // longest any single wait may take, in cycles
    localparam int SIG_I_WRITE = 0;   // selectors for the wait loop
    localparam int SIG_I_BUSY  = 1;
    localparam int SIG_D_WRITE = 2;
    localparam int SIG_D_BUSY  = 3;
    localparam int SIG_RAM_RD  = 4;

    logic                clk_i;
    logic                rst_i;
    logic                instr_req_i;
    l1_addr_t            instr_addr_i;
    logic                instr_l1_hit_i;
    logic                instr_miss_next_i;
    logic                instr_l2_hit_i;
    logic                data_req_i;
    l1_addr_t            data_addr_i;
    logic                data_l1_hit_i;
    logic                data_l2_hit_i;
    logic                ram_done_i = 1'b0; // owned by the memory model below
    logic                instr_busy_o;
    logic                instr_miss_o;
    logic                instr_l2_read_o;
    logic                instr_l1_write_o;
    logic                instr_write_next_o;
    logic                instr_fill_start_o;
    logic                l2_p2_write_o;
    logic [`CC_BE_W-1:0] l2_p2_be_o;
    l1_addr_t            l2_p2_addr_o;
    logic                data_busy_o;
    logic                data_miss_o;
    logic                data_l2_read_o;
    logic                data_l1_write_o;
    logic                data_fill_start_o;
    logic                l2_p1_write_o;
    logic [`CC_BE_W-1:0] l2_p1_be_o;
    logic                ram_read_o;
    ram_addr_t           ram_read_addr_o;

    int                  seed = 85791;
    int                  err_cnt = 0;    // value and timeout failures seen here
    int                  test_cnt = 0;
    int                  fail_tests = 0;
    int                  test_start_err; // error total when the current test began
    int                  gap_cnt = 0;    // idle cycles before the next ram_done_i
    bit                  saw_l2_read;
    bit                  saw_miss;
    bit                  saw_ram_read;
    bit                  saw_write_next;
    l1_addr_t            l2_addr_seen;   // L2 port 2 address while the instr line is written
    l1_addr_t            addr_a;
    l1_addr_t            addr_b;
    l1_addr_t            next_addr;
    ram_addr_t           addr_log[$];    // one entry per memory word handed back
    logic [`CC_BE_W-1:0] p1_be_log[$];
    logic [`CC_BE_W-1:0] p2_be_log[$];

    cache_ctrl_top DUT (.*);

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // memory model: answers each word after a random gap and logs what was asked
    always @(negedge clk_i) begin
        if (rst_i || !ram_read_o) begin
            ram_done_i = 1'b0;
            gap_cnt    = $unsigned($random(seed)) % 3;
        end else if (ram_done_i) begin
            ram_done_i = 1'b0; // one-cycle strobe per word
            gap_cnt    = $unsigned($random(seed)) % 4;
        end else if (gap_cnt > 0) begin
            gap_cnt = gap_cnt - 1;
        end else begin
            ram_done_i = 1'b1;
            addr_log.push_back(ram_read_addr_o);
            p1_be_log.push_back(l2_p1_be_o);
            p2_be_log.push_back(l2_p2_be_o);
        end
    end

    // sticky flags so a test can ask afterwards whether something ever happened
    always @(negedge clk_i) begin
        saw_l2_read    = saw_l2_read || instr_l2_read_o || data_l2_read_o;
        saw_miss       = saw_miss || instr_miss_o || data_miss_o;
        saw_ram_read   = saw_ram_read || ram_read_o;
        saw_write_next = saw_write_next || instr_write_next_o;
    end

    function automatic int total_errors();
        return err_cnt + int'(DUT.u_chk.fail_cnt); // includes failed assertions
    endfunction

    function automatic l1_addr_t rand_addr();
        return l1_addr_t'($random(seed));
    endfunction

    function automatic l1_addr_t line_of(input l1_addr_t a);
        return a & ~l1_addr_t'(15); // first byte of the 16-byte line
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SIG_I_WRITE: return instr_l1_write_o;
            SIG_I_BUSY:  return instr_busy_o;
            SIG_D_WRITE: return data_l1_write_o;
            SIG_D_BUSY:  return data_busy_o;
            default:     return ram_read_o;
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic wait_level(input int sel, input logic level, input string what);
        int cnt;
        cnt = 0;
        while (probe(sel) !== level && cnt < WAIT_LIMIT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (probe(sel) !== level) begin
            $display("timeout at %0t ns: %s did not happen within %0d cycles",
                     $time, what, WAIT_LIMIT);
            err_cnt++;
        end
    endtask

    task automatic begin_test();
        test_start_err = total_errors();
        saw_l2_read    = 1'b0;
        saw_miss       = 1'b0;
        saw_ram_read   = 1'b0;
        saw_write_next = 1'b0;
        addr_log.delete();
        p1_be_log.delete();
        p2_be_log.delete();
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (total_errors() == test_start_err) begin
            $display("test %0d %s: pass", test_cnt, name);
        end else begin
            fail_tests++;
            $display("test %0d %s: fail", test_cnt, name);
        end
    endtask

    // one missing read on either port, carried until the port goes idle again
    task automatic read_port(input bit instr, input l1_addr_t addr, input bit next_line,
                             input bit l2_hit);
        string tag;
        tag = instr ? "instr" : "data";
        if (instr) begin
            instr_addr_i      = addr;
            instr_l1_hit_i    = next_line; // a next-line case hits the current line
            instr_miss_next_i = next_line;
            instr_l2_hit_i    = l2_hit;
            instr_req_i       = 1'b1;
        end else begin
            data_addr_i   = addr;
            data_l1_hit_i = 1'b0;
            data_l2_hit_i = l2_hit;
            data_req_i    = 1'b1;
        end
        @(negedge clk_i);
        if (instr) begin
            instr_req_i = 1'b0;
        end else begin
            data_req_i = 1'b0;
        end
        wait_level(instr ? SIG_I_WRITE : SIG_D_WRITE, 1'b1, {tag, " L1 line write"});
        if (instr) begin
            l2_addr_seen = l2_p2_addr_o;
        end
        repeat (3) @(negedge clk_i); // L1 still reports a miss, so the port must hold
        check({tag, " busy_o while L1 misses"}, 1, instr ? instr_busy_o : data_busy_o);
        check({tag, " l1_write_o after two cycles"}, 0,
              instr ? instr_l1_write_o : data_l1_write_o);
        if (instr) begin
            instr_l1_hit_i    = 1'b1;
            instr_miss_next_i = 1'b0;
        end else begin
            data_l1_hit_i = 1'b1;
        end
        wait_level(instr ? SIG_I_BUSY : SIG_D_BUSY, 1'b0, {tag, " busy release"});
        instr_l1_hit_i = instr ? 1'b0 : instr_l1_hit_i;
        data_l1_hit_i  = instr ? data_l1_hit_i : 1'b0;
    endtask

    // four words starting at logged entry first, all for one port
    task automatic check_refill(input int first, input l1_addr_t line, input bit instr);
        logic [`CC_BE_W-1:0] nib;
        for (int i = 0; i < `CC_BEATS; i++) begin
            nib = 16'h000F << (4 * i);
            check("ram_read_addr_o", {`CC_RAM_BASE, line + l1_addr_t'(4 * i)},
                  addr_log[first + i]);
            check(instr ? "l2_p2_be_o" : "l2_p1_be_o", nib,
                  instr ? p2_be_log[first + i] : p1_be_log[first + i]);
            check(instr ? "l2_p1_be_o" : "l2_p2_be_o", 0,
                  instr ? p1_be_log[first + i] : p2_be_log[first + i]);
        end
    endtask

    task automatic check_idle();
        check("instr_busy_o", 0, instr_busy_o);
        check("instr_miss_o", 0, instr_miss_o);
        check("instr_l2_read_o", 0, instr_l2_read_o);
        check("instr_l1_write_o", 0, instr_l1_write_o);
        check("instr_write_next_o", 0, instr_write_next_o);
        check("instr_fill_start_o", 0, instr_fill_start_o);
        check("l2_p2_write_o", 0, l2_p2_write_o);
        check("data_busy_o", 0, data_busy_o);
        check("data_miss_o", 0, data_miss_o);
        check("data_l2_read_o", 0, data_l2_read_o);
        check("data_l1_write_o", 0, data_l1_write_o);
        check("data_fill_start_o", 0, data_fill_start_o);
        check("l2_p1_write_o", 0, l2_p1_write_o);
        check("ram_read_o", 0, ram_read_o);
        check("l2_p1_be_o", 0, l2_p1_be_o);
        check("l2_p2_be_o", 0, l2_p2_be_o);
    endtask

    initial begin
        rst_i             = 1'b1;
        instr_req_i       = 1'b0;
        instr_addr_i      = '0;
        instr_l1_hit_i    = 1'b0;
        instr_miss_next_i = 1'b0;
        instr_l2_hit_i    = 1'b0;
        data_req_i        = 1'b0;
        data_addr_i       = '0;
        data_l1_hit_i     = 1'b0;
        data_l2_hit_i     = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);

        begin_test(); // a hit is busy for exactly one cycle
        instr_addr_i      = rand_addr();
        instr_l1_hit_i    = 1'b1;
        instr_miss_next_i = 1'b0;
        instr_req_i       = 1'b1;
        @(negedge clk_i);
        instr_req_i = 1'b0;
        check("instr_busy_o after request", 1, instr_busy_o);
        @(negedge clk_i);
        check("instr_busy_o after hit", 0, instr_busy_o);
        repeat (4) @(negedge clk_i);
        check("l2_read_o during hit", 0, saw_l2_read);
        check("ram_read_o during hit", 0, saw_ram_read);
        instr_l1_hit_i = 1'b0;
        end_test("L1 hit");

        begin_test();
        read_port(1'b1, rand_addr(), 1'b0, 1'b1);
        check("l2_read_o on L1 miss", 1, saw_l2_read);
        check("miss_o on L1 miss", 1, saw_miss);
        check("ram_read_o on L2 hit", 0, saw_ram_read);
        end_test("L1 miss, L2 hit");

        begin_test();
        addr_a = rand_addr();
        read_port(1'b0, addr_a, 1'b0, 1'b0);
        check("data refill word count", `CC_BEATS, addr_log.size());
        if (addr_log.size() == `CC_BEATS) begin
            check_refill(0, line_of(addr_a), 1'b0);
        end
        end_test("data L2 miss refill");

        begin_test(); // instr wins from idle, data waits with its request raised
        addr_a = rand_addr();
        addr_b = rand_addr();
        fork
            read_port(1'b1, addr_a, 1'b0, 1'b0);
            read_port(1'b0, addr_b, 1'b0, 1'b0);
        join
        check("refill word count for both ports", 2 * `CC_BEATS, addr_log.size());
        if (addr_log.size() == 2 * `CC_BEATS) begin
            check_refill(0, line_of(addr_a), 1'b1);
            check_refill(`CC_BEATS, line_of(addr_b), 1'b0);
        end
        end_test("both ports miss");

        begin_test(); // low nibble E or F puts the next line in another block
        addr_a    = rand_addr() | l1_addr_t'(14);
        next_addr = addr_a + l1_addr_t'(`CC_NEXT_STEP);
        read_port(1'b1, addr_a, 1'b1, 1'b0);
        check("instr_write_next_o", 1, saw_write_next);
        check("l2_p2_addr_o", next_addr, l2_addr_seen);
        check("next-line refill word count", `CC_BEATS, addr_log.size());
        if (addr_log.size() == `CC_BEATS) begin
            check_refill(0, line_of(next_addr), 1'b1);
        end
        end_test("next line");

        begin_test(); // reset lands in the middle of a data refill
        data_addr_i   = rand_addr();
        data_l1_hit_i = 1'b0;
        data_l2_hit_i = 1'b0;
        data_req_i    = 1'b1;
        @(negedge clk_i);
        data_req_i = 1'b0;
        wait_level(SIG_RAM_RD, 1'b1, "data refill before reset");
        rst_i = 1'b1;
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);
        check_idle();
        end_test("reset");

        $display("tests run %0d, failing %0d, errors %0d", test_cnt, fail_tests, total_errors());
        if (total_errors() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/cache_ctrl_pkg.sv
design/l1_miss_fsm.sv
design/mem_read_arbiter.sv
design/refill_seq.sv
design/cache_ctrl_top.sv
verif/cache_ctrl_chk.sv
verif/cache_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and decide the verdict from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cache_ctrl_tb
./obj_dir/Vcache_ctrl_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q "^Simulation PASSED$" sim.log
